//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_saturn_decoder
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the pass message appears as a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/saturn_config.svh
// saturn decoder config: bus widths and counts shared by the decoder blocks
`ifndef SATURN_CONFIG_SVH
`define SATURN_CONFIG_SVH

// program counter width, one address per nibble
`define SATURN_ADDR_W 20

// the cpu moves data one nibble at a time
`define SATURN_NIB_W 4

// immediate buffer depth in nibbles
// a 3F load fills all 16 of them
`define SATURN_IMM_NIBS 16

// position counter into the immediate buffer
// needs one spare bit so a full load of 16 can be counted
`define SATURN_POS_W 5

`endif

//--- common/saturn_pkg.sv
// saturn decoder package: alu operation codes and decoder block states
package saturn_pkg;

  // operation handed to the alu
  // encoding follows the alu op table of the core
  typedef enum logic [4:0] {
    NONE     = 5'd0,
    ZERO     = 5'd1,
    COPY     = 5'd2,
    EXCH     = 5'd3,
    INC      = 5'd4,
    DEC      = 5'd5,
    JMP_REL2 = 5'd6,
    JMP_REL3 = 5'd7
  } alu_op_t;

  // which instruction group currently owns the nibble stream
  // IDLE means the next accepted nibble is an opcode
  typedef enum logic [2:0] {
    IDLE = 3'd0,
    // 0x: one more nibble selects the operation
    B0X  = 3'd1,
    // 2n: P=n
    B2X  = 3'd2,
    // 3n: length nibble then n+1 data nibbles
    B3X  = 3'd3,
    // 4x/5x: two offset nibbles
    JMP2 = 3'd4,
    // 6x/7x: three offset nibbles
    JMP3 = 3'd5
  } dec_block_t;

endpackage

//--- decoder/saturn_decoder.sv
// saturn decoder top: nibble sequencer plus group decoders, merged result outputs
`timescale 1ns/1ps
`include "saturn_config.svh"

module saturn_decoder (
  input  logic                                       i_clk,
  input  logic                                       i_reset,
  input  logic                                       i_en_dec,
  input  logic                                       i_stalled,
  input  logic [`SATURN_ADDR_W-1:0]                  i_pc,
  input  logic [`SATURN_NIB_W-1:0]                   i_nibble,
  output logic                                       o_ins_decoded,
  output logic [`SATURN_ADDR_W-1:0]                  o_ins_addr,
  output logic                                       o_dec_error,
  output saturn_pkg::alu_op_t                        o_alu_op,
  output logic                                       o_ins_alu_op,
  output logic                                       o_push,
  output logic                                       o_pop,
  output logic                                       o_ins_rtn,
  output logic                                       o_set_xm,
  output logic                                       o_set_carry,
  output logic                                       o_carry_val,
  output logic                                       o_en_intr,
  output logic                                       o_ins_set_mode,
  output logic                                       o_mode_dec,
  output logic                                       o_test_carry,
  output logic [`SATURN_NIB_W-1:0]                   o_imm_value,
  output logic [`SATURN_IMM_NIBS*`SATURN_NIB_W-1:0]  o_mem_load,
  output logic [`SATURN_POS_W-1:0]                   o_mem_pos
);

  saturn_pkg::dec_block_t block;
  logic                   take;
  logic                   g0_done;
  logic                   g0_err;
  logic                   g0_ins_alu_op;
  saturn_pkg::alu_op_t    g0_alu_op;
  logic                   g0_push;
  logic                   g0_pop;
  logic                   g0_carry_val;
  logic                   ld_done;
  logic                   ld_ins_alu_op;
  saturn_pkg::alu_op_t    ld_alu_op;
  logic                   ld_push;
  logic                   ld_carry_val;

  saturn_nibble_seq u_seq (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_en_dec      (i_en_dec),
    .i_stalled     (i_stalled),
    .i_pc          (i_pc),
    .i_nibble      (i_nibble),
    .i_done        (g0_done | ld_done),
    .i_err         (g0_err),
    .o_block       (block),
    .o_take        (take),
    .o_ins_decoded (o_ins_decoded),
    .o_ins_addr    (o_ins_addr),
    .o_dec_error   (o_dec_error)
  );

  saturn_group0_dec u_group0 (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_block        (block),
    .i_take         (take),
    .i_nibble       (i_nibble),
    .o_done         (g0_done),
    .o_err          (g0_err),
    .o_ins_rtn      (o_ins_rtn),
    .o_set_xm       (o_set_xm),
    .o_set_carry    (o_set_carry),
    .o_carry_val    (g0_carry_val),
    .o_en_intr      (o_en_intr),
    .o_ins_set_mode (o_ins_set_mode),
    .o_mode_dec     (o_mode_dec),
    .o_ins_alu_op   (g0_ins_alu_op),
    .o_alu_op       (g0_alu_op),
    .o_push         (g0_push),
    .o_pop          (g0_pop)
  );

  // opcode nibble rides the same bus, the loader keeps it at block entry
  saturn_imm_loader u_loader (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_block        (block),
    .i_take         (take),
    .i_first_nibble (i_nibble),
    .i_nibble       (i_nibble),
    .o_done         (ld_done),
    .o_ins_alu_op   (ld_ins_alu_op),
    .o_alu_op       (ld_alu_op),
    .o_push         (ld_push),
    .o_test_carry   (o_test_carry),
    .o_carry_val    (ld_carry_val),
    .o_imm_value    (o_imm_value),
    .o_mem_load     (o_mem_load),
    .o_mem_pos      (o_mem_pos)
  );

  // only the owning decoder drives non-zero values, so OR is a merge
  assign o_alu_op     = saturn_pkg::alu_op_t'(g0_alu_op | ld_alu_op);
  assign o_ins_alu_op = g0_ins_alu_op | ld_ins_alu_op;
  assign o_push       = g0_push | ld_push;
  assign o_pop        = g0_pop;
  assign o_carry_val  = g0_carry_val | ld_carry_val;

endmodule

//--- decoder/saturn_group0_dec.sv
// saturn 0x group decoder: returns, SETHEX/SETDEC, RSTK copies, ST and P alu ops
`timescale 1ns/1ps
`include "saturn_config.svh"

module saturn_group0_dec (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  saturn_pkg::dec_block_t    i_block,
  input  logic                      i_take,
  input  logic [`SATURN_NIB_W-1:0]  i_nibble,
  output logic                      o_done,
  output logic                      o_err,
  output logic                      o_ins_rtn,
  output logic                      o_set_xm,
  output logic                      o_set_carry,
  output logic                      o_carry_val,
  output logic                      o_en_intr,
  output logic                      o_ins_set_mode,
  output logic                      o_mode_dec,
  output logic                      o_ins_alu_op,
  output saturn_pkg::alu_op_t       o_alu_op,
  output logic                      o_push,
  output logic                      o_pop
);

  logic sel;

  // second nibble of a 0x instruction
  assign sel    = i_take && (i_block == saturn_pkg::B0X);
  // 0E opens the logical ops, not supported
  assign o_done = sel && (i_nibble != 4'hE);
  assign o_err  = sel && (i_nibble == 4'hE);

  always_ff @(posedge i_clk) begin
    if (i_reset || (i_block != saturn_pkg::IDLE)) begin
      // cleared while any instruction is in flight
      o_ins_rtn      <= 1'b0;
      o_set_xm       <= 1'b0;
      o_set_carry    <= 1'b0;
      o_carry_val    <= 1'b0;
      o_en_intr      <= 1'b0;
      o_ins_set_mode <= 1'b0;
      o_mode_dec     <= 1'b0;
      o_ins_alu_op   <= 1'b0;
      o_alu_op       <= saturn_pkg::NONE;
      o_push         <= 1'b0;
      o_pop          <= 1'b0;
    end
    if (!i_reset && o_done) begin
      case (i_nibble)
        // RTNSXM RTN RTNSC RTNCC RTI
        4'h0, 4'h1, 4'h2, 4'h3, 4'hF: begin
          o_ins_rtn   <= 1'b1;
          o_pop       <= 1'b1;
          o_set_xm    <= (i_nibble == 4'h0);
          o_set_carry <= !i_nibble[3] && i_nibble[1];
          o_carry_val <= i_nibble[1] && !i_nibble[0] && !i_nibble[3];
          o_en_intr   <= i_nibble[3];
        end
        // SETHEX / SETDEC
        4'h4, 4'h5: begin
          o_ins_set_mode <= 1'b1;
          o_mode_dec     <= i_nibble[0];
        end
        // RSTK=C pushes, C=RSTK pops
        4'h6, 4'h7: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= saturn_pkg::COPY;
          o_push       <= !i_nibble[0];
          o_pop        <= i_nibble[0];
        end
        4'h8: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= saturn_pkg::ZERO;
        end
        // C=ST and ST=C
        4'h9, 4'hA: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= saturn_pkg::COPY;
        end
        4'hB: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= saturn_pkg::EXCH;
        end
        // P=P+1 / P=P-1
        default: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= i_nibble[0] ? saturn_pkg::DEC : saturn_pkg::INC;
        end
      endcase
    end
  end

  a_rtn_not_mode: assert property (
    @(posedge i_clk) disable iff (i_reset)
    !(o_ins_rtn && o_ins_set_mode)
  );

endmodule

//--- decoder/saturn_imm_loader.sv
// saturn immediate loader: P=n, LC(n+1) and relative jumps, gathers operand nibbles
`timescale 1ns/1ps
`include "saturn_config.svh"

module saturn_imm_loader (
  input  logic                                       i_clk,
  input  logic                                       i_reset,
  input  saturn_pkg::dec_block_t                     i_block,
  input  logic                                       i_take,
  input  logic [`SATURN_NIB_W-1:0]                   i_first_nibble,
  input  logic [`SATURN_NIB_W-1:0]                   i_nibble,
  output logic                                       o_done,
  output logic                                       o_ins_alu_op,
  output saturn_pkg::alu_op_t                        o_alu_op,
  output logic                                       o_push,
  output logic                                       o_test_carry,
  output logic                                       o_carry_val,
  output logic [`SATURN_NIB_W-1:0]                   o_imm_value,
  output logic [`SATURN_IMM_NIBS*`SATURN_NIB_W-1:0]  o_mem_load,
  output logic [`SATURN_POS_W-1:0]                   o_mem_pos
);

  logic [`SATURN_NIB_W-1:0] opcode_q;
  logic                     own;
  logic                     active_q;
  logic                     entry;
  logic                     len_seen_q;
  logic                     len_take;
  logic                     data_take;
  logic [`SATURN_POS_W-1:0] pos_cur;
  logic [`SATURN_POS_W-1:0] pos_next;
  logic [`SATURN_POS_W-1:0] target;

  assign own = (i_block == saturn_pkg::B2X) || (i_block == saturn_pkg::B3X) ||
               (i_block == saturn_pkg::JMP2) || (i_block == saturn_pkg::JMP3);

  // first cycle spent in one of our blocks
  assign entry = own && !active_q;

  // 3n: the first continuation nibble is the length, not data
  assign len_take  = i_take && (i_block == saturn_pkg::B3X) && !len_seen_q;
  assign data_take = i_take && own && !len_take;

  assign pos_cur  = entry ? '0 : o_mem_pos;
  assign pos_next = pos_cur + 1'b1;

  // data nibbles expected per block
  always_comb begin
    case (i_block)
      saturn_pkg::B2X:  target = 'd1;
      saturn_pkg::B3X:  target = {{(`SATURN_POS_W-`SATURN_NIB_W){1'b0}}, opcode_q} + 1'b1;
      saturn_pkg::JMP2: target = 'd2;
      saturn_pkg::JMP3: target = 'd3;
      default:          target = '0;
    endcase
  end

  assign o_done = data_take && (pos_next == target);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      active_q     <= 1'b0;
      len_seen_q   <= 1'b0;
      o_ins_alu_op <= 1'b0;
      o_alu_op     <= saturn_pkg::NONE;
      o_push       <= 1'b0;
      o_test_carry <= 1'b0;
      o_carry_val  <= 1'b0;
      o_mem_pos    <= '0;
    end else begin
      active_q   <= own;
      len_seen_q <= (i_block == saturn_pkg::B3X) && (len_seen_q || len_take);
      if (entry) begin
        // controls follow from the block and the opcode alone
        o_ins_alu_op <= 1'b1;
        o_push       <= 1'b0;
        o_test_carry <= 1'b0;
        o_carry_val  <= 1'b0;
        o_mem_pos    <= '0;
        case (i_block)
          saturn_pkg::JMP2: begin
            o_alu_op     <= saturn_pkg::JMP_REL2;
            o_test_carry <= 1'b1;
            // GOC on 4, GONC on 5
            o_carry_val  <= !opcode_q[0];
          end
          saturn_pkg::JMP3: begin
            o_alu_op <= saturn_pkg::JMP_REL3;
            // GOSUB pushes the return address
            o_push   <= opcode_q[0];
          end
          default: o_alu_op <= saturn_pkg::COPY;
        endcase
      end else if (!own && (i_block != saturn_pkg::IDLE)) begin
        // a 0x instruction owns the outputs
        o_ins_alu_op <= 1'b0;
        o_alu_op     <= saturn_pkg::NONE;
        o_push       <= 1'b0;
        o_test_carry <= 1'b0;
        o_carry_val  <= 1'b0;
        o_mem_pos    <= '0;
      end
      if (data_take) begin
        o_mem_pos <= pos_next;
      end
    end
  end

  // opcode captured on the accept edge, the last edge seen in IDLE
  always_ff @(posedge i_clk) begin
    if (i_block == saturn_pkg::IDLE) begin
      opcode_q <= i_first_nibble;
    end else if (len_take) begin
      opcode_q <= i_nibble;
    end
    if (data_take) begin
      // lowest nibble first
      o_mem_load[pos_cur*`SATURN_NIB_W +: `SATURN_NIB_W] <= i_nibble;
      o_imm_value <= i_nibble;
    end
  end

  a_pos_in_range: assert property (
    @(posedge i_clk) disable iff (i_reset)
    (own && active_q) |-> (o_mem_pos <= target)
  );

endmodule

//--- decoder/saturn_nibble_seq.sv
// saturn nibble sequencer that dispatches opcodes and tracks block, completion and error
`timescale 1ns/1ps
`include "saturn_config.svh"

module saturn_nibble_seq (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic                          i_en_dec,
  input  logic                          i_stalled,
  input  logic [`SATURN_ADDR_W-1:0]     i_pc,
  input  logic [`SATURN_NIB_W-1:0]      i_nibble,
  input  logic                          i_done,
  input  logic                          i_err,
  output saturn_pkg::dec_block_t        o_block,
  output logic                          o_take,
  output logic                          o_ins_decoded,
  output logic [`SATURN_ADDR_W-1:0]     o_ins_addr,
  output logic                          o_dec_error
);

  logic accept;
  logic first_nibble;
  logic start;

  // a nibble is consumed only when enabled and not stalled
  assign accept = i_en_dec && !i_stalled;

  // IDLE block means the next nibble opens an instruction
  assign first_nibble = (o_block == saturn_pkg::IDLE);

  // once an error is flagged no new instruction is started
  assign start = accept && first_nibble && !o_dec_error;

  // continuation nibble strobe for the group decoders
  assign o_take = accept && !first_nibble;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_block       <= saturn_pkg::IDLE;
      o_ins_decoded <= 1'b0;
      o_dec_error   <= 1'b0;
    end else if (start) begin
      o_ins_decoded <= 1'b0;
      case (i_nibble)
        4'h0: o_block <= saturn_pkg::B0X;
        4'h2: o_block <= saturn_pkg::B2X;
        4'h3: o_block <= saturn_pkg::B3X;
        // GOC / GONC
        4'h4, 4'h5: o_block <= saturn_pkg::JMP2;
        // GOTO / GOSUB
        4'h6, 4'h7: o_block <= saturn_pkg::JMP3;
        // 1x, 8x..Fx are not handled here
        default: o_dec_error <= 1'b1;
      endcase
    end else if (o_take) begin
      if (i_done) begin
        o_block       <= saturn_pkg::IDLE;
        o_ins_decoded <= 1'b1;
      end else if (i_err) begin
        // block drops to IDLE but start stays blocked
        o_block     <= saturn_pkg::IDLE;
        o_dec_error <= 1'b1;
      end
    end
  end

  // address of the opcode nibble
  always_ff @(posedge i_clk) begin
    if (start) begin
      o_ins_addr <= i_pc;
    end
  end

  a_decoded_xor_error: assert property (
    @(posedge i_clk) disable iff (i_reset)
    !(o_ins_decoded && o_dec_error)
  );

endmodule

//--- list.f
+incdir+common
common/saturn_pkg.sv
decoder/saturn_nibble_seq.sv
decoder/saturn_group0_dec.sv
decoder/saturn_imm_loader.sv
decoder/saturn_decoder.sv
tb/saturn_clkgen.sv
tb/tb_saturn_decoder.sv

//--- tb/saturn_clkgen.sv
// testbench clock and reset source: 100 ns clock, 4-cycle reset at start or on request
`timescale 1ns/1ps

module saturn_clkgen (
  input  logic i_restart,
  output logic o_clk,
  output logic o_reset
);

  logic [2:0] rst_cnt = 3'd4;

  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk;
  end

  // reset cycles left, reloaded by a restart request
  always @(posedge o_clk) begin
    if (i_restart) begin
      rst_cnt <= 3'd4;
    end else if (rst_cnt != 3'd0) begin
      rst_cnt <= rst_cnt - 3'd1;
    end
  end

  assign o_reset = (rst_cnt != 3'd0);

endmodule

//--- tb/tb_saturn_decoder.sv
// saturn decoder testbench with directed tests of every supported group, gaps and decode errors
`timescale 1ns/1ps
`include "saturn_config.svh"

module tb_saturn_decoder;

  logic                                      clk;
  logic                                      rst;
  logic                                      restart;
  logic                                      i_en_dec;
  logic                                      i_stalled;
  logic [`SATURN_ADDR_W-1:0]                 i_pc;
  logic [`SATURN_NIB_W-1:0]                  i_nibble;
  logic                                      o_ins_decoded;
  logic [`SATURN_ADDR_W-1:0]                 o_ins_addr;
  logic                                      o_dec_error;
  saturn_pkg::alu_op_t                       o_alu_op;
  logic                                      o_ins_alu_op;
  logic                                      o_push;
  logic                                      o_pop;
  logic                                      o_ins_rtn;
  logic                                      o_set_xm;
  logic                                      o_set_carry;
  logic                                      o_carry_val;
  logic                                      o_en_intr;
  logic                                      o_ins_set_mode;
  logic                                      o_mode_dec;
  logic                                      o_test_carry;
  logic [`SATURN_NIB_W-1:0]                  o_imm_value;
  logic [`SATURN_IMM_NIBS*`SATURN_NIB_W-1:0] o_mem_load;
  logic [`SATURN_POS_W-1:0]                  o_mem_pos;

  // nibbles of the instruction under test and the operand nibbles expected back
  logic [3:0] prog[$];
  logic [3:0] operand[$];
  string      cur_test;
  int         test_errs;
  int         total_errs;
  int         tests_run;
  int         tests_failed;

  saturn_clkgen u_clkgen (
    .i_restart (restart),
    .o_clk     (clk),
    .o_reset   (rst)
  );

  saturn_decoder DUT (
    .i_clk          (clk),
    .i_reset        (rst),
    .i_en_dec       (i_en_dec),
    .i_stalled      (i_stalled),
    .i_pc           (i_pc),
    .i_nibble       (i_nibble),
    .o_ins_decoded  (o_ins_decoded),
    .o_ins_addr     (o_ins_addr),
    .o_dec_error    (o_dec_error),
    .o_alu_op       (o_alu_op),
    .o_ins_alu_op   (o_ins_alu_op),
    .o_push         (o_push),
    .o_pop          (o_pop),
    .o_ins_rtn      (o_ins_rtn),
    .o_set_xm       (o_set_xm),
    .o_set_carry    (o_set_carry),
    .o_carry_val    (o_carry_val),
    .o_en_intr      (o_en_intr),
    .o_ins_set_mode (o_ins_set_mode),
    .o_mode_dec     (o_mode_dec),
    .o_test_carry   (o_test_carry),
    .o_imm_value    (o_imm_value),
    .o_mem_load     (o_mem_load),
    .o_mem_pos      (o_mem_pos)
  );

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("ERR %0t %s expected %0b got %0b", $time, name, exp, got);
      test_errs++;
    end
  endtask

  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
      test_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("test %s %s (%0d errors)", cur_test, (test_errs == 0) ? "ok" : "FAILED",
             test_errs);
  endtask

  // waits on falling edges until reset is released
  task automatic wait_reset();
    bit released;
    released = 1'b0;
    for (int c = 0; c < 16; c++) begin
      @(negedge clk);
      if (!rst) begin
        released = 1'b1;
        break;
      end
    end
    assert (released) else begin
      $display("timeout at %0t: reset was not released within 16 cycles", $time);
      test_errs++;
    end
  endtask

  task automatic apply_reset();
    restart = 1'b1;
    @(negedge clk);
    restart = 1'b0;
    wait_reset();
  endtask

  // feeds prog one nibble per accepted cycle and then waits for decode or error
  task automatic issue_prog(input bit gaps, input logic [`SATURN_ADDR_W-1:0] pc);
    int n_gap;
    bit seen;
    foreach (prog[k]) begin
      n_gap = gaps ? int'($urandom_range(0, 3)) : 0;
      // idle cycles are disabled or stalled with junk on the bus
      repeat (n_gap) begin
        i_en_dec  = 1'($urandom_range(0, 1));
        i_stalled = i_en_dec ? 1'b1 : 1'($urandom_range(0, 1));
        i_nibble  = 4'($urandom);
        i_pc      = 20'($urandom);
        @(negedge clk);
      end
      i_en_dec  = 1'b1;
      i_stalled = 1'b0;
      i_nibble  = prog[k];
      i_pc      = (k == 0) ? pc : 20'($urandom);
      @(negedge clk);
    end
    i_en_dec = 1'b0;
    seen     = 1'b0;
    for (int c = 0; c < 64; c++) begin
      if (o_ins_decoded || o_dec_error) begin
        seen = 1'b1;
        break;
      end
      @(negedge clk);
    end
    assert (seen) else begin
      $display("timeout at %0t: no decode and no error within 64 cycles", $time);
      test_errs++;
    end
  endtask

  task automatic check_common(input logic [`SATURN_ADDR_W-1:0] pc,
                              input saturn_pkg::alu_op_t e_alu, input logic e_flag,
                              input logic e_push, input logic e_pop, input logic e_cval);
    check_bit("o_ins_decoded", o_ins_decoded, 1'b1);
    check_bit("o_dec_error", o_dec_error, 1'b0);
    check_word("o_ins_addr", 64'(o_ins_addr), 64'(pc));
    check_word("o_alu_op", 64'(o_alu_op), 64'(e_alu));
    check_bit("o_ins_alu_op", o_ins_alu_op, e_flag);
    check_bit("o_push", o_push, e_push);
    check_bit("o_pop", o_pop, e_pop);
    check_bit("o_carry_val", o_carry_val, e_cval);
  endtask

  task automatic run_g0(input logic [3:0] nib, input bit gaps);
    logic [`SATURN_ADDR_W-1:0] pc;
    saturn_pkg::alu_op_t       e_alu;
    logic                      e_rtn;
    logic                      e_xm;
    logic                      e_setc;
    logic                      e_cval;
    logic                      e_intr;
    logic                      e_mode;
    logic                      e_mdec;
    logic                      e_flag;
    logic                      e_push;
    logic                      e_pop;
    pc     = 20'($urandom);
    e_alu  = saturn_pkg::NONE;
    {e_rtn, e_xm, e_setc, e_cval, e_intr} = 5'b0;
    {e_mode, e_mdec, e_flag, e_push, e_pop} = 5'b0;
    case (nib)
      4'h0, 4'h1, 4'h2, 4'h3, 4'hF: begin
        e_rtn  = 1'b1;
        e_pop  = 1'b1;
        e_xm   = (nib == 4'h0);
        e_setc = (nib == 4'h2) || (nib == 4'h3);
        e_cval = (nib == 4'h2);
        e_intr = (nib == 4'hF);
      end
      4'h4, 4'h5: begin
        e_mode = 1'b1;
        e_mdec = (nib == 4'h5);
      end
      4'h6: begin
        e_alu  = saturn_pkg::COPY;
        e_push = 1'b1;
      end
      4'h7: begin
        e_alu = saturn_pkg::COPY;
        e_pop = 1'b1;
      end
      4'h8: e_alu = saturn_pkg::ZERO;
      4'h9, 4'hA: e_alu = saturn_pkg::COPY;
      4'hB: e_alu = saturn_pkg::EXCH;
      4'hC: e_alu = saturn_pkg::INC;
      default: e_alu = saturn_pkg::DEC;
    endcase
    e_flag = (nib >= 4'h6) && (nib <= 4'hD);
    prog = '{4'h0, nib};
    issue_prog(gaps, pc);
    check_common(pc, e_alu, e_flag, e_push, e_pop, e_cval);
    check_bit("o_ins_rtn", o_ins_rtn, e_rtn);
    check_bit("o_set_xm", o_set_xm, e_xm);
    check_bit("o_set_carry", o_set_carry, e_setc);
    check_bit("o_en_intr", o_en_intr, e_intr);
    check_bit("o_ins_set_mode", o_ins_set_mode, e_mode);
    check_bit("o_mode_dec", o_mode_dec, e_mdec);
    check_bit("o_test_carry", o_test_carry, 1'b0);
  endtask

  // operand nibbles come back lowest first with the count in o_mem_pos and the last in o_imm_value
  task automatic check_operand();
    foreach (operand[i]) begin
      check_word($sformatf("o_mem_load[%0d]", i), 64'(o_mem_load[i*4 +: 4]), 64'(operand[i]));
    end
    check_word("o_mem_pos", 64'(o_mem_pos), 64'(operand.size()));
    check_word("o_imm_value", 64'(o_imm_value), 64'(operand[$]));
    check_bit("o_ins_rtn", o_ins_rtn, 1'b0);
    check_bit("o_ins_set_mode", o_ins_set_mode, 1'b0);
  endtask

  // P=n when is_lc is low and LC with n+1 data nibbles when it is high
  task automatic run_load(input bit is_lc, input bit gaps);
    logic [`SATURN_ADDR_W-1:0] pc;
    logic [3:0]                n;
    logic [3:0]                d;
    pc = 20'($urandom);
    n  = 4'($urandom);
    operand.delete();
    prog = '{is_lc ? 4'h3 : 4'h2, n};
    if (is_lc) begin
      for (int i = 0; i <= int'(n); i++) begin
        d = 4'($urandom);
        prog.push_back(d);
        operand.push_back(d);
      end
    end else begin
      operand.push_back(n);
    end
    issue_prog(gaps, pc);
    check_common(pc, saturn_pkg::COPY, 1'b1, 1'b0, 1'b0, 1'b0);
    check_bit("o_test_carry", o_test_carry, 1'b0);
    check_operand();
  endtask

  task automatic run_jump(input logic [3:0] op, input bit gaps);
    logic [`SATURN_ADDR_W-1:0] pc;
    logic [3:0]                d;
    int                        cnt;
    pc  = 20'($urandom);
    cnt = (op < 4'h6) ? 2 : 3;
    operand.delete();
    prog = '{op};
    for (int i = 0; i < cnt; i++) begin
      d = 4'($urandom);
      prog.push_back(d);
      operand.push_back(d);
    end
    issue_prog(gaps, pc);
    check_common(pc, (cnt == 2) ? saturn_pkg::JMP_REL2 : saturn_pkg::JMP_REL3, 1'b1,
                 op == 4'h7, 1'b0, op == 4'h4);
    check_bit("o_test_carry", o_test_carry, cnt == 2);
    check_operand();
  endtask

  initial begin
    logic [3:0] nib;
    void'($urandom(43919));
    restart      = 1'b0;
    i_en_dec     = 1'b0;
    i_stalled    = 1'b0;
    i_pc         = '0;
    i_nibble     = '0;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;

    begin_test("reset");
    wait_reset();
    check_bit("o_ins_decoded", o_ins_decoded, 1'b0);
    check_bit("o_dec_error", o_dec_error, 1'b0);
    check_bit("o_ins_rtn", o_ins_rtn, 1'b0);
    check_bit("o_push", o_push, 1'b0);
    check_bit("o_pop", o_pop, 1'b0);
    check_bit("o_ins_alu_op", o_ins_alu_op, 1'b0);
    check_bit("o_ins_set_mode", o_ins_set_mode, 1'b0);
    check_word("o_alu_op", 64'(o_alu_op), 64'(saturn_pkg::NONE));
    end_test();

    begin_test("group0");
    for (int i = 0; i < 16; i++) begin
      if (i != 14) run_g0(4'(i), 1'b0);
    end
    end_test();

    begin_test("loads");
    repeat (6) begin
      run_load(1'b0, 1'b0);
      run_load(1'b1, 1'b0);
    end
    end_test();

    begin_test("jumps");
    repeat (3) begin
      for (int op = 4; op < 8; op++) run_jump(4'(op), 1'b0);
    end
    end_test();

    begin_test("gaps");
    repeat (24) begin
      case ($urandom_range(0, 3))
        0: begin
          nib = 4'($urandom_range(0, 14));
          run_g0((nib == 4'hE) ? 4'hF : nib, 1'b1);
        end
        1: run_load(1'b0, 1'b1);
        2: run_load(1'b1, 1'b1);
        default: run_jump(4'($urandom_range(4, 7)), 1'b1);
      endcase
    end
    end_test();

    begin_test("errors");
    prog = '{4'h8};
    issue_prog(1'b0, 20'($urandom));
    check_bit("o_dec_error", o_dec_error, 1'b1);
    check_bit("o_ins_decoded", o_ins_decoded, 1'b0);
    // a valid instruction after the error must not decode
    prog = '{4'h0, 4'h1};
    issue_prog(1'b0, 20'($urandom));
    repeat (4) @(negedge clk);
    check_bit("o_dec_error", o_dec_error, 1'b1);
    check_bit("o_ins_decoded", o_ins_decoded, 1'b0);
    apply_reset();
    check_bit("o_dec_error", o_dec_error, 1'b0);
    prog = '{4'h0, 4'hE};
    issue_prog(1'b0, 20'($urandom));
    check_bit("o_dec_error", o_dec_error, 1'b1);
    check_bit("o_ins_decoded", o_ins_decoded, 1'b0);
    apply_reset();
    check_bit("o_dec_error", o_dec_error, 1'b0);
    end_test();

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
